/* verilog.f */
hw/bgpu_cfg_pkg.sv
hw/bgpu_inst_pkg.sv
hw/operand_collector.sv
hw/register_file.sv
hw/collector_unit.sv
sim/tb_collector_unit.sv

/* Makefile */
# Verilator flow for the operand collection stage
TOP := tb_collector_unit

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	verilator --lint-only --timing --top-module collector_unit -f verilog.f

clean:
	rm -rf obj_dir

/* sim/tb_collector_unit.sv */
// ##################################################
// Testbench for the collector unit, random dispatch and
// writeback checked against a shadow register model
// ##################################################
`timescale 1ns/100ps

module tb_collector_unit
    import bgpu_cfg_pkg::*, bgpu_inst_pkg::*;
();

    logic       clk_i = 1'b0;
    logic       rst_n_i;
    logic       disp_valid_i;
    disp_req_t  disp_req_i;
    logic       disp_ready_o;
    logic       wb_valid_i;
    rf_wb_t     wb_i;
    logic       issue_valid_o;
    opc_issue_t issue_o;
    logic       eu_ready_i;

    // Shadow registers and expected-issue table, indexed by iid
    warp_data_t shadow [NUM_WARPS][NUM_REGS];
    opc_issue_t exp_tab [NUM_TAGS*NUM_WARPS];
    disp_req_t  disp_tab [NUM_TAGS*NUM_WARPS];
    logic       pending [NUM_TAGS*NUM_WARPS];

    logic [15:0] lfsr_q;
    string       test_name;
    int          in_dut;
    logic        stall_en;
    logic        saw_full;
    logic        was_stalled;
    opc_issue_t  held_issue;
    int          err_issue;
    int          err_data;
    int          err_bit;
    int          err_other;

    collector_unit collector_unit_i (.*);

    always #2 clk_i = ~clk_i;

    // ##################################################
    // Random numbers
    // ##################################################

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            r      = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // ##################################################
    // Compare tasks
    // ##################################################

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            err_bit++;
            $display("** Error [%s] %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_data(input string what, input warp_data_t exp, input warp_data_t act);
        if (act !== exp) begin
            err_data++;
            $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    // Operands that are not required are don't-care
    task automatic check_issue(input string what, input opc_issue_t exp, input opc_issue_t act,
                               input logic [OPERANDS_PER_INST-1:0] req);
        opc_issue_t exp_m;
        opc_issue_t act_m;
        exp_m = exp;
        act_m = act;
        for (int i = 0; i < OPERANDS_PER_INST; i++) begin
            if (!req[i]) begin
                exp_m.operands[i] = '0;
                act_m.operands[i] = '0;
            end
        end
        if (act_m !== exp_m) begin
            err_issue++;
            $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp_m, act_m);
            // Narrow down to the operand
            for (int i = 0; i < OPERANDS_PER_INST; i++) begin
                if (req[i]) begin
                    check_data($sformatf("%s operand %0d", what, i),
                               exp.operands[i], act.operands[i]);
                end
            end
        end
    endtask

    task automatic print_counts();
        $display("Errors: issue %0d, data %0d, bit %0d, other %0d",
                 err_issue, err_data, err_bit, err_other);
    endtask

    task automatic report_timeout(input string msg);
        $display("Timeout in test %s: %s", test_name, msg);
        print_counts();
        $display("SIMULATION FAILED");
        $finish;
    endtask

    // ##################################################
    // Model helpers
    // ##################################################

    // Any free tag of the warp
    function automatic iid_t alloc_iid(input wid_t wid);
        tag_t tag;
        tag = tag_t'(rand_bits(2));
        for (int k = 0; k < NUM_TAGS; k++) begin
            if (pending[iid_t'({tag, wid})]) begin
                tag = tag + tag_t'(1);
            end
        end
        return iid_t'({tag, wid});
    endfunction

    // Register still to be read by an outstanding instruction
    function automatic logic reg_busy(input wid_t wid, input reg_idx_t idx);
        logic busy;
        busy = 1'b0;
        for (int id = 0; id < NUM_TAGS * NUM_WARPS; id++) begin
            for (int i = 0; i < OPERANDS_PER_INST; i++) begin
                if (pending[id] && disp_tab[id].iid[WID_WIDTH-1:0] == wid
                        && disp_tab[id].src_required[i] && disp_tab[id].src[i] == idx) begin
                    busy = 1'b1;
                end
            end
        end
        return busy;
    endfunction

    // Shadow merge and one-cycle strobe
    task automatic drive_wb(input wid_t wid, input reg_idx_t idx, input warp_data_t data,
                            input act_mask_t mask);
        for (int t = 0; t < WARP_WIDTH; t++) begin
            if (mask[t]) begin
                shadow[wid][idx][t*REG_WIDTH +: REG_WIDTH] = data[t*REG_WIDTH +: REG_WIDTH];
            end
        end
        wb_i.wid      = wid;
        wb_i.reg_idx  = idx;
        wb_i.data     = data;
        wb_i.act_mask = mask;
        wb_valid_i    = 1'b1;
    endtask

    task automatic random_wb(input logic partial);
        wid_t      wid;
        reg_idx_t  idx;
        act_mask_t mask;
        wid  = wid_t'(rand_bits(2));
        idx  = reg_idx_t'(rand_bits(4));
        mask = partial ? act_mask_t'(rand_bits(4)) : 4'hF;
        if (!reg_busy(wid, idx)) begin
            drive_wb(wid, idx, warp_data_t'(rand_bits(32)), mask);
        end
    endtask

    task automatic random_req(output disp_req_t req);
        req.iid          = alloc_iid(wid_t'(rand_bits(2)));
        req.pc           = pc_t'(rand_bits(16));
        req.act_mask     = act_mask_t'(rand_bits(4));
        req.inst.opcode  = opcode_t'(6'(rand_bits(2)) + 6'd1);
        req.inst.imm     = IMM_WIDTH'(rand_bits(IMM_WIDTH));
        req.dst          = reg_idx_t'(rand_bits(4));
        req.src_required = 2'(rand_bits(2));
        req.src[0]       = reg_idx_t'(rand_bits(4));
        req.src[1]       = reg_idx_t'(rand_bits(4));
    endtask

    // ##################################################
    // Cycle stepping and issue side
    // ##################################################

    // Runs at the falling edge, outputs settled since the rising edge
    task automatic watch_issue();
        iid_t id;
        check_bit("disp_ready_o", in_dut < NUM_COLLECTORS, disp_ready_o);
        if (!disp_ready_o) begin
            saw_full = 1'b1;
        end
        if (was_stalled) begin
            check_bit("issue_valid_o held", 1'b1, issue_valid_o);
            check_issue("issue_o held", held_issue, issue_o,
                        disp_tab[held_issue.iid].src_required);
        end
        eu_ready_i = stall_en ? (rand_bits(2) == 32'd0) : 1'b1;
        if (issue_valid_o && eu_ready_i) begin
            id = issue_o.iid;
            if (!pending[id]) begin
                err_other++;
                $display("Error in test %s: iid %0d issued while not outstanding", test_name, id);
            end else begin
                check_issue($sformatf("issue of iid %0d", id), exp_tab[id], issue_o,
                            disp_tab[id].src_required);
                pending[id] = 1'b0;
                in_dut--;
            end
        end
        was_stalled = issue_valid_o && !eu_ready_i;
        held_issue  = issue_o;
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        @(negedge clk_i);
        wb_valid_i = 1'b0;
        watch_issue();
    endtask

    // Expected issue comes from the shadow at dispatch time
    task automatic send_inst(input disp_req_t req, input logic wb_mix, input logic partial);
        opc_issue_t exp;
        int         waited;
        logic       done;
        exp.iid      = req.iid;
        exp.pc       = req.pc;
        exp.act_mask = req.act_mask;
        exp.inst     = req.inst;
        exp.dst      = req.dst;
        for (int i = 0; i < OPERANDS_PER_INST; i++) begin
            exp.operands[i] = shadow[req.iid[WID_WIDTH-1:0]][req.src[i]];
        end
        exp_tab[req.iid]  = exp;
        disp_tab[req.iid] = req;
        pending[req.iid]  = 1'b1;
        disp_req_i        = req;
        disp_valid_i      = 1'b1;
        waited            = 0;
        done              = 1'b0;
        while (!done) begin
            if (wb_mix && rand_bits(1) == 32'd1) begin
                random_wb(partial);
            end
            // Handshake completes at the coming edge
            if (disp_ready_o) begin
                done = 1'b1;
                in_dut++;
            end
            next_cycle();
            waited++;
            if (!done && waited > 400) begin
                report_timeout("dispatch was never accepted");
            end
        end
        disp_valid_i = 1'b0;
    endtask

    task automatic traffic(input int n, input logic wb_mix, input logic partial);
        disp_req_t req;
        for (int k = 0; k < n; k++) begin
            random_req(req);
            send_inst(req, wb_mix, partial);
        end
    endtask

    task automatic send_directed(input logic [1:0] req_bits, input reg_idx_t s0,
                                 input reg_idx_t s1);
        disp_req_t req;
        random_req(req);
        req.src_required = req_bits;
        req.src[0]       = s0;
        req.src[1]       = s1;
        send_inst(req, 1'b0, 1'b0);
    endtask

    // Wait until the collectors are empty, then audit the iid table
    task automatic drain();
        int waited;
        waited = 0;
        while (in_dut != 0 && waited < 1000) begin
            next_cycle();
            waited++;
        end
        if (in_dut != 0) begin
            err_other++;
            $display("Error in test %s: drain gave up with %0d instructions left",
                     test_name, in_dut);
        end
        for (int id = 0; id < NUM_TAGS * NUM_WARPS; id++) begin
            if (pending[id]) begin
                err_other++;
                $display("Error in test %s: iid %0d was dispatched but never issued",
                         test_name, id);
            end
        end
    endtask

    // ##################################################
    // Test sequence
    // ##################################################

    initial begin
        lfsr_q       = 16'd45019;
        rst_n_i      = 1'b0;
        disp_valid_i = 1'b0;
        disp_req_i   = '0;
        wb_valid_i   = 1'b0;
        wb_i         = '0;
        eu_ready_i   = 1'b0;
        in_dut       = 0;
        stall_en     = 1'b0;
        saw_full     = 1'b0;
        was_stalled  = 1'b0;
        held_issue   = '0;
        err_issue    = 0;
        err_data     = 0;
        err_bit      = 0;
        err_other    = 0;
        for (int id = 0; id < NUM_TAGS * NUM_WARPS; id++) begin
            pending[id] = 1'b0;
        end

        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        // Idle state out of reset
        test_name = "reset";
        check_bit("issue_valid_o", 1'b0, issue_valid_o);
        check_bit("disp_ready_o", 1'b1, disp_ready_o);

        // Fill every warp register
        test_name = "preload";
        for (int w = 0; w < NUM_WARPS; w++) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                drive_wb(wid_t'(w), reg_idx_t'(r), warp_data_t'(rand_bits(32)), 4'hF);
                next_cycle();
            end
        end

        test_name = "random_ops";
        traffic(40, 1'b0, 1'b0);
        drain();

        // No operand, single operands, same-bank pairs
        test_name = "directed";
        send_directed(2'b00, 4'd0, 4'd0);
        send_directed(2'b01, 4'd5, 4'd0);
        send_directed(2'b10, 4'd0, 4'd9);
        send_directed(2'b11, 4'd4, 4'd10);
        send_directed(2'b11, 4'd3, 4'd3);
        send_directed(2'b11, 4'd7, 4'd13);
        drain();

        test_name = "backpressure";
        stall_en  = 1'b1;
        saw_full  = 1'b0;
        traffic(60, 1'b0, 1'b0);
        drain();
        if (!saw_full) begin
            err_other++;
            $display("Error in test %s: both collectors were never busy at once", test_name);
        end

        // Partial-mask writebacks between dispatches
        test_name = "wb_mix";
        traffic(60, 1'b1, 1'b1);
        drain();

        test_name = "final";
        stall_en  = 1'b0;
        traffic(20, 1'b0, 1'b0);
        drain();

        print_counts();
        if (err_issue + err_data + err_bit + err_other == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule : tb_collector_unit

/* hw/collector_unit.sv */
// ##################################################
// Operand collection stage, steers dispatch into free
// collectors and issues completed instructions
// ##################################################
`timescale 1ns/100ps

module collector_unit
    import bgpu_cfg_pkg::*, bgpu_inst_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,

    // Dispatch
    input  logic       disp_valid_i,
    input  disp_req_t  disp_req_i,
    output logic       disp_ready_o,

    // Writeback
    input  logic       wb_valid_i,
    input  rf_wb_t     wb_i,

    // Issue to the EUs
    output logic       issue_valid_o,
    output opc_issue_t issue_o,
    input  logic       eu_ready_i
);

    // Collector side
    logic [NUM_COLLECTORS-1:0]       opc_free;
    logic [NUM_COLLECTORS-1:0]       opc_disp_valid;
    logic [NUM_COLLECTORS-1:0]       opc_valid;
    logic [NUM_COLLECTORS-1:0]       opc_issue_ready;
    opc_issue_t [NUM_COLLECTORS-1:0] opc_issue;

    // Register file side
    logic [NUM_RD_PORTS-1:0]         rf_rd_valid;
    rf_read_req_t [NUM_RD_PORTS-1:0] rf_rd_req;
    logic [NUM_RD_PORTS-1:0]         rf_rd_ready;
    logic [NUM_RD_PORTS-1:0]         rf_rsp_valid;
    warp_data_t [NUM_RD_PORTS-1:0]   rf_rsp_data;

    // Steering and issue arbitration
    coll_idx_t disp_idx;
    coll_idx_t rr_ptr_q;
    coll_idx_t rr_idx;
    coll_idx_t lock_idx_q;
    coll_idx_t gnt_idx;
    logic      lock_q;

    // ##################################################
    // Dispatch steering
    // ##################################################

    // Lowest free collector
    always_comb begin
        disp_idx = '0;
        for (int c = NUM_COLLECTORS - 1; c >= 0; c--) begin
            if (opc_free[c]) begin
                disp_idx = coll_idx_t'(c);
            end
        end
    end

    assign disp_ready_o = |opc_free;

    // Collector pool, read ports flattened per operand
    for (genvar c = 0; c < NUM_COLLECTORS; c++) begin : gen_opc
        assign opc_disp_valid[c]  = disp_valid_i && (disp_idx == coll_idx_t'(c));
        assign opc_issue_ready[c] = eu_ready_i && (gnt_idx == coll_idx_t'(c));

        operand_collector operand_collector_i (
            .clk_i         (clk_i),
            .rst_n_i       (rst_n_i),
            .disp_valid_i  (opc_disp_valid[c]),
            .disp_req_i    (disp_req_i),
            .ready_o       (opc_free[c]),
            .rd_valid_o    (rf_rd_valid[c*OPERANDS_PER_INST +: OPERANDS_PER_INST]),
            .rd_req_o      (rf_rd_req[c*OPERANDS_PER_INST +: OPERANDS_PER_INST]),
            .rd_ready_i    (rf_rd_ready[c*OPERANDS_PER_INST +: OPERANDS_PER_INST]),
            .rsp_valid_i   (rf_rsp_valid[c*OPERANDS_PER_INST +: OPERANDS_PER_INST]),
            .rsp_data_i    (rf_rsp_data[c*OPERANDS_PER_INST +: OPERANDS_PER_INST]),
            .issue_valid_o (opc_valid[c]),
            .issue_o       (opc_issue[c]),
            .issue_ready_i (opc_issue_ready[c])
        );
    end : gen_opc

    register_file register_file_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rd_valid_i  (rf_rd_valid),
        .rd_req_i    (rf_rd_req),
        .rd_ready_o  (rf_rd_ready),
        .rsp_valid_o (rf_rsp_valid),
        .rsp_data_o  (rf_rsp_data),
        .wb_valid_i  (wb_valid_i),
        .wb_i        (wb_i)
    );

    // ##################################################
    // Round-robin issue
    // ##################################################

    // First ready collector at or after the pointer
    always_comb begin
        coll_idx_t cand;
        logic      found;
        cand   = '0;
        found  = 1'b0;
        rr_idx = rr_ptr_q;
        for (int k = 0; k < NUM_COLLECTORS; k++) begin
            cand = coll_idx_t'((int'(rr_ptr_q) + k) % NUM_COLLECTORS);
            if (!found && opc_valid[cand]) begin
                found  = 1'b1;
                rr_idx = cand;
            end
        end
    end

    // Stalled choice stays put
    assign gnt_idx       = lock_q ? lock_idx_q : rr_idx;
    assign issue_valid_o = opc_valid[gnt_idx];
    assign issue_o       = opc_issue[gnt_idx];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rr_ptr_q   <= '0;
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
        end else if (issue_valid_o && eu_ready_i) begin
            // Winner drops to lowest priority
            rr_ptr_q <= coll_idx_t'((int'(gnt_idx) + 1) % NUM_COLLECTORS);
            lock_q   <= 1'b0;
        end else if (issue_valid_o) begin
            lock_q     <= 1'b1;
            lock_idx_q <= gnt_idx;
        end
    end

    // ##################################################
    // Assertions
    // ##################################################

    // EU sees a stable instruction under back-pressure
    a_issue_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        issue_valid_o && !eu_ready_i |=> issue_valid_o && $stable(issue_o))
        else $error("issue output changed while stalled");

endmodule : collector_unit

/* hw/register_file.sv */
// ##################################################
// Two-bank warp register file, one read per bank per
// cycle, writeback wins over reads
// ##################################################
`timescale 1ns/100ps

module register_file
    import bgpu_cfg_pkg::*, bgpu_inst_pkg::*;
(
    input  logic                             clk_i,
    input  logic                             rst_n_i,

    // Read request ports
    input  logic [NUM_RD_PORTS-1:0]          rd_valid_i,
    input  rf_read_req_t [NUM_RD_PORTS-1:0]  rd_req_i,
    output logic [NUM_RD_PORTS-1:0]          rd_ready_o,

    // Read responses, one cycle after grant
    output logic [NUM_RD_PORTS-1:0]          rsp_valid_o,
    output warp_data_t [NUM_RD_PORTS-1:0]    rsp_data_o,

    // Writeback
    input  logic                             wb_valid_i,
    input  rf_wb_t                           wb_i
);

    // Warp and upper index bits address a bank row
    function automatic bank_addr_t row_addr(input wid_t wid, input reg_idx_t idx);
        return {wid, idx[REG_IDX_WIDTH-1:BANK_SEL_WIDTH]};
    endfunction

    // ##################################################
    // Storage
    // ##################################################

    warp_data_t mem_q [NUM_BANKS][BANK_DEPTH];

    warp_data_t [NUM_BANKS-1:0]     bank_rdata_q;
    bank_sel_t  [NUM_RD_PORTS-1:0]  rsp_bank_q;
    logic [NUM_RD_PORTS-1:0]        rsp_valid_q;

    // Port decode
    bank_sel_t  [NUM_RD_PORTS-1:0]  port_bank;
    bank_addr_t [NUM_RD_PORTS-1:0]  port_addr;
    bank_sel_t                      wb_bank;
    bank_addr_t                     wb_addr;
    logic [NUM_BANKS-1:0]           wb_busy;

    // Per bank grant
    logic [NUM_BANKS-1:0]                   bank_gnt;
    bank_addr_t [NUM_BANKS-1:0]             bank_addr;
    logic [NUM_BANKS-1:0][NUM_RD_PORTS-1:0] bank_hits;

    for (genvar p = 0; p < NUM_RD_PORTS; p++) begin : gen_port
        assign port_bank[p] = rd_req_i[p].reg_idx[BANK_SEL_WIDTH-1:0];
        assign port_addr[p] = row_addr(rd_req_i[p].wid, rd_req_i[p].reg_idx);
    end : gen_port

    assign wb_bank = wb_i.reg_idx[BANK_SEL_WIDTH-1:0];
    assign wb_addr = row_addr(wb_i.wid, wb_i.reg_idx);

    // ##################################################
    // Bank arbitration
    // ##################################################

    always_comb begin
        bank_gnt   = '0;
        bank_addr  = '0;
        rd_ready_o = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            // Writeback blocks the bank
            wb_busy[b] = wb_valid_i && (wb_bank == bank_sel_t'(b));
            // Lowest port wins
            for (int p = 0; p < NUM_RD_PORTS; p++) begin
                if (rd_valid_i[p] && port_bank[p] == bank_sel_t'(b)
                        && !wb_busy[b] && !bank_gnt[b]) begin
                    bank_gnt[b]   = 1'b1;
                    bank_addr[b]  = port_addr[p];
                    rd_ready_o[p] = 1'b1;
                end
            end
        end
    end

    // Bank reads, port bookkeeping and masked writeback
    always_ff @(posedge clk_i) begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (bank_gnt[b]) begin
                bank_rdata_q[b] <= mem_q[b][bank_addr[b]];
            end
        end
        for (int p = 0; p < NUM_RD_PORTS; p++) begin
            if (rd_ready_o[p]) begin
                rsp_bank_q[p] <= port_bank[p];
            end
        end
        // Merge per thread under the active mask
        if (wb_valid_i) begin
            for (int t = 0; t < WARP_WIDTH; t++) begin
                if (wb_i.act_mask[t]) begin
                    mem_q[wb_bank][wb_addr][t*REG_WIDTH +: REG_WIDTH] <=
                        wb_i.data[t*REG_WIDTH +: REG_WIDTH];
                end
            end
        end
    end

    // Response strobes
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= '0;
        end else begin
            rsp_valid_q <= rd_ready_o;
        end
    end

    assign rsp_valid_o = rsp_valid_q;

    // Each port picks the row its bank read last
    for (genvar p = 0; p < NUM_RD_PORTS; p++) begin : gen_rsp
        assign rsp_data_o[p] = bank_rdata_q[rsp_bank_q[p]];
    end : gen_rsp

    // ##################################################
    // Assertions
    // ##################################################

    for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_chk
        for (genvar p = 0; p < NUM_RD_PORTS; p++) begin : gen_hit
            assign bank_hits[b][p] = rd_ready_o[p] && (port_bank[p] == bank_sel_t'(b));
        end : gen_hit

        // Single read per bank and cycle
        a_one_read : assert property (@(posedge clk_i) disable iff (!rst_n_i)
            $countones(bank_hits[b]) <= 1)
            else $error("bank %0d granted more than one read", b);
    end : gen_chk

endmodule : register_file

/* hw/operand_collector.sv */
// ##################################################
// One collector slot that holds an instruction until
// its operands are read and then offers it for issue
// ##################################################
`timescale 1ns/100ps

module operand_collector
    import bgpu_cfg_pkg::*, bgpu_inst_pkg::*;
(
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,

    // Dispatch
    input  logic                                 disp_valid_i,
    input  disp_req_t                            disp_req_i,
    output logic                                 ready_o,

    // Read requests to the register file
    output logic [OPERANDS_PER_INST-1:0]         rd_valid_o,
    output rf_read_req_t [OPERANDS_PER_INST-1:0] rd_req_o,
    input  logic [OPERANDS_PER_INST-1:0]         rd_ready_i,

    // Read responses
    input  logic [OPERANDS_PER_INST-1:0]         rsp_valid_i,
    input  warp_data_t [OPERANDS_PER_INST-1:0]   rsp_data_i,

    // Issue
    output logic                                 issue_valid_o,
    output opc_issue_t                           issue_o,
    input  logic                                 issue_ready_i
);

    // Instruction fields carried to issue
    typedef struct packed {
        iid_t       iid;
        pc_t        pc;
        act_mask_t  act_mask;
        bgpu_inst_t inst;
        reg_idx_t   dst;
    } inst_info_t;

    // ##################################################
    // Slot state
    // ##################################################

    logic                               occupied_q;
    logic [OPERANDS_PER_INST-1:0]       requested_q;
    logic [OPERANDS_PER_INST-1:0]       ready_q;

    inst_info_t                         info_q;
    reg_idx_t [OPERANDS_PER_INST-1:0]   src_q;
    warp_data_t [OPERANDS_PER_INST-1:0] data_q;

    logic                               accept;
    logic                               issue_fire;
    logic [OPERANDS_PER_INST-1:0]       rd_fire;

    // Free slot takes the next instruction
    assign ready_o    = !occupied_q;
    assign accept     = disp_valid_i && ready_o;
    assign issue_fire = issue_valid_o && issue_ready_i;

    // Read requests
    for (genvar i = 0; i < OPERANDS_PER_INST; i++) begin : gen_req
        // Ask once per required operand
        assign rd_valid_o[i]       = occupied_q && !requested_q[i];
        assign rd_req_o[i].wid     = info_q.iid[WID_WIDTH-1:0];
        assign rd_req_o[i].reg_idx = src_q[i];
        assign rd_fire[i]          = rd_valid_o[i] && rd_ready_i[i];
    end : gen_req

    // Control flags
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            occupied_q  <= 1'b0;
            requested_q <= '0;
            ready_q     <= '0;
        end else if (accept) begin
            occupied_q  <= 1'b1;
            // Unused operands count as requested and ready
            requested_q <= ~disp_req_i.src_required;
            ready_q     <= ~disp_req_i.src_required;
        end else begin
            if (issue_fire) begin
                occupied_q <= 1'b0;
            end
            requested_q <= requested_q | rd_fire;
            ready_q     <= ready_q | rsp_valid_i;
        end
    end

    // Instruction and operand payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            info_q.iid      <= disp_req_i.iid;
            info_q.pc       <= disp_req_i.pc;
            info_q.act_mask <= disp_req_i.act_mask;
            info_q.inst     <= disp_req_i.inst;
            info_q.dst      <= disp_req_i.dst;
            src_q           <= disp_req_i.src;
        end
        // Capture on the response strobe
        for (int i = 0; i < OPERANDS_PER_INST; i++) begin
            if (rsp_valid_i[i]) begin
                data_q[i] <= rsp_data_i[i];
            end
        end
    end

    // ##################################################
    // Issue
    // ##################################################

    // All operands in hand
    assign issue_valid_o     = occupied_q && (&ready_q);
    assign issue_o.iid       = info_q.iid;
    assign issue_o.pc        = info_q.pc;
    assign issue_o.act_mask  = info_q.act_mask;
    assign issue_o.inst      = info_q.inst;
    assign issue_o.dst       = info_q.dst;
    assign issue_o.operands  = data_q;

    // ##################################################
    // Assertions
    // ##################################################

    for (genvar i = 0; i < OPERANDS_PER_INST; i++) begin : gen_chk
        // Only a held operand still missing its data goes to the register file
        a_no_req_free : assert property (@(posedge clk_i) disable iff (!rst_n_i)
            rd_valid_o[i] |-> occupied_q && !ready_q[i])
            else $error("operand %0d requested with no read outstanding", i);

        // Register file only answers outstanding reads
        a_rsp_expected : assert property (@(posedge clk_i) disable iff (!rst_n_i)
            rsp_valid_i[i] |-> occupied_q && requested_q[i] && !ready_q[i])
            else $error("unexpected response on operand %0d", i);
    end : gen_chk

endmodule : operand_collector

/* hw/bgpu_inst_pkg.sv */
// ##################################################
// Instruction records between dispatch, collectors and EUs
// Needs bgpu_cfg_pkg compiled first
// ##################################################
package bgpu_inst_pkg;

    import bgpu_cfg_pkg::*;

    // Collector pool
    localparam int unsigned NUM_COLLECTORS = 2;
    // One register file read port per collector operand
    localparam int unsigned NUM_RD_PORTS   = NUM_COLLECTORS * OPERANDS_PER_INST;
    localparam int unsigned IMM_WIDTH      = 10;

    typedef logic [$clog2(NUM_COLLECTORS)-1:0] coll_idx_t;

    typedef enum logic [5:0] {
        OP_NOP = 6'h00,
        OP_ADD = 6'h01,
        OP_SUB = 6'h02,
        OP_MUL = 6'h03,
        OP_AND = 6'h04,
        OP_OR  = 6'h05,
        OP_LDI = 6'h10
    } opcode_t;

    // Instruction word
    typedef struct packed {
        opcode_t              opcode;
        logic [IMM_WIDTH-1:0] imm;
    } bgpu_inst_t;

    // From the warp dispatcher
    typedef struct packed {
        iid_t                                iid;
        pc_t                                 pc;
        act_mask_t                           act_mask;
        bgpu_inst_t                          inst;
        reg_idx_t                            dst;
        logic [OPERANDS_PER_INST-1:0]        src_required;
        reg_idx_t [OPERANDS_PER_INST-1:0]    src;
    } disp_req_t;

    // To the execution units
    typedef struct packed {
        iid_t                                iid;
        pc_t                                 pc;
        act_mask_t                           act_mask;
        bgpu_inst_t                          inst;
        reg_idx_t                            dst;
        warp_data_t [OPERANDS_PER_INST-1:0]  operands;
    } opc_issue_t;

endpackage : bgpu_inst_pkg

/* hw/bgpu_cfg_pkg.sv */
// ##################################################
// Compute unit sizes and register file types
// Import into any block that touches warp registers
// ##################################################
package bgpu_cfg_pkg;

    // Machine sizes
    localparam int unsigned NUM_WARPS         = 4;
    localparam int unsigned WARP_WIDTH        = 4;
    localparam int unsigned REG_WIDTH         = 8;
    localparam int unsigned NUM_REGS          = 16;
    localparam int unsigned NUM_TAGS          = 4;
    localparam int unsigned OPERANDS_PER_INST = 2;
    localparam int unsigned NUM_BANKS         = 2;

    // Derived widths
    localparam int unsigned WID_WIDTH      = $clog2(NUM_WARPS);
    localparam int unsigned REG_IDX_WIDTH  = $clog2(NUM_REGS);
    localparam int unsigned TAG_WIDTH      = $clog2(NUM_TAGS);
    localparam int unsigned PC_WIDTH       = 16;
    localparam int unsigned BANK_SEL_WIDTH = $clog2(NUM_BANKS);
    // Registers of all warps spread over the banks
    localparam int unsigned BANK_DEPTH     = NUM_WARPS * NUM_REGS / NUM_BANKS;

    typedef logic [WID_WIDTH-1:0]                 wid_t;
    typedef logic [REG_IDX_WIDTH-1:0]             reg_idx_t;
    typedef logic [TAG_WIDTH-1:0]                 tag_t;
    // Tag on top, warp id in the low bits
    typedef logic [$bits(tag_t)+$bits(wid_t)-1:0] iid_t;
    typedef logic [PC_WIDTH-1:0]                  pc_t;
    typedef logic [WARP_WIDTH-1:0]                act_mask_t;
    typedef logic [REG_WIDTH*WARP_WIDTH-1:0]      warp_data_t;

    // Bank is the low bits of the register index
    typedef logic [BANK_SEL_WIDTH-1:0]                      bank_sel_t;
    typedef logic [WID_WIDTH+REG_IDX_WIDTH-BANK_SEL_WIDTH-1:0] bank_addr_t;

    // One warp register read
    typedef struct packed {
        wid_t     wid;
        reg_idx_t reg_idx;
    } rf_read_req_t;

    // Writeback, only active threads land
    typedef struct packed {
        wid_t       wid;
        reg_idx_t   reg_idx;
        warp_data_t data;
        act_mask_t  act_mask;
    } rf_wb_t;

endpackage : bgpu_cfg_pkg
